//--- logic/core_defs.svh
// Integer pipeline definitions

`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// --------------------
// Widths and sizes.
// --------------------
`define XLEN        64
`define INSTR_W     32
`define REG_ADDR_W  5
`define NUM_REGS    32
`define SHAMT_W     6

// --------------------
// Major opcodes.
// --------------------
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111

// --------------------
// Funct3 encodings.
// --------------------
`define FUNCT3_ADD_SUB  3'b000
`define FUNCT3_SLL      3'b001
`define FUNCT3_SLT      3'b010
`define FUNCT3_SLTU     3'b011
`define FUNCT3_XOR      3'b100
`define FUNCT3_SR       3'b101
`define FUNCT3_OR       3'b110
`define FUNCT3_AND      3'b111

// Funct7 for plain and alternate (SUB, SRA) forms.
`define FUNCT7_BASE     7'b0000000
`define FUNCT7_ALT      7'b0100000

`endif

//--- logic/core_pkg.sv
// Integer pipeline types

`include "core_defs.svh"

package core_pkg;

    // --------------------
    // Vector types.
    // --------------------
    typedef logic [`XLEN-1:0]       xlen_t;
    typedef logic [`INSTR_W-1:0]    instr_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // ALU operations with PASS_B for LUI.
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B
    } alu_op_e;

    // --------------------
    // Stage packets.
    // --------------------
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      use_imm;
        xlen_t     imm;
        alu_op_e   alu_op;
        logic      reg_we;
        xlen_t     rs1_data;
        xlen_t     rs2_data;
    } dec_pkt_t;

    // Shared by execute and result outputs.
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        xlen_t     data;
    } wb_pkt_t;

endpackage

//--- logic/decode_stage.sv
// Instruction decode stage

`timescale 1ns/100ps

`include "core_defs.svh"

module decode_stage import core_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_instr_valid,
    input  instr_t    i_instr,
    input  xlen_t     i_rs1_data,
    input  xlen_t     i_rs2_data,
    output reg_addr_t o_rs1_addr,
    output reg_addr_t o_rs2_addr,
    output dec_pkt_t  o_dec
);

    // --------------------
    // Instruction fields.
    // --------------------
    logic [6:0] s_opcode;
    logic [2:0] s_funct3;
    logic [6:0] s_funct7;
    reg_addr_t  s_rd;
    xlen_t      s_imm_i;
    xlen_t      s_imm_u;

    // Decoded controls.
    alu_op_e  s_alu_op;
    logic     s_use_imm;
    xlen_t    s_imm;
    logic     s_supported;
    logic     s_funct7_ok;
    dec_pkt_t s_dec_next;

    assign s_opcode   = i_instr[6:0];
    assign s_rd       = i_instr[11:7];
    assign s_funct3   = i_instr[14:12];
    assign o_rs1_addr = i_instr[19:15];
    assign o_rs2_addr = i_instr[24:20];
    assign s_funct7   = i_instr[31:25];

    // Sign extended I and U immediates.
    assign s_imm_i = {{(`XLEN-12){i_instr[31]}}, i_instr[31:20]};
    assign s_imm_u = {{(`XLEN-32){i_instr[31]}}, i_instr[31:12], 12'b0};

    // Alternate funct7 only exists for SUB and SRA.
    assign s_funct7_ok = (s_funct7 == `FUNCT7_BASE) ||
                         ((s_funct7 == `FUNCT7_ALT) &&
                          ((s_funct3 == `FUNCT3_ADD_SUB) || (s_funct3 == `FUNCT3_SR)));

    always_comb begin
        s_alu_op    = ALU_ADD;
        s_use_imm   = 1'b0;
        s_imm       = s_imm_i;
        s_supported = 1'b0;
        case (s_opcode)
            `OPC_OP: begin
                s_supported = s_funct7_ok;
                case (s_funct3)
                    `FUNCT3_ADD_SUB: s_alu_op = s_funct7[5] ? ALU_SUB : ALU_ADD;
                    `FUNCT3_SLL:     s_alu_op = ALU_SLL;
                    `FUNCT3_SLT:     s_alu_op = ALU_SLT;
                    `FUNCT3_SLTU:    s_alu_op = ALU_SLTU;
                    `FUNCT3_XOR:     s_alu_op = ALU_XOR;
                    `FUNCT3_SR:      s_alu_op = s_funct7[5] ? ALU_SRA : ALU_SRL;
                    `FUNCT3_OR:      s_alu_op = ALU_OR;
                    default:         s_alu_op = ALU_AND;
                endcase
            end
            `OPC_OP_IMM: begin
                s_use_imm   = 1'b1;
                s_supported = 1'b1;
                case (s_funct3)
                    `FUNCT3_ADD_SUB: s_alu_op = ALU_ADD;
                    `FUNCT3_SLT:     s_alu_op = ALU_SLT;
                    `FUNCT3_XOR:     s_alu_op = ALU_XOR;
                    `FUNCT3_OR:      s_alu_op = ALU_OR;
                    `FUNCT3_AND:     s_alu_op = ALU_AND;
                    // Immediate shifts and SLTIU are not kept.
                    default:         s_supported = 1'b0;
                endcase
            end
            `OPC_LUI: begin
                s_use_imm   = 1'b1;
                s_imm       = s_imm_u;
                s_alu_op    = ALU_PASS_B;
                s_supported = 1'b1;
            end
            default: s_supported = 1'b0;
        endcase
    end

    // Packet with the register file data read this cycle.
    always_comb begin
        s_dec_next.valid    = i_instr_valid;
        s_dec_next.rd       = s_rd;
        s_dec_next.rs1      = o_rs1_addr;
        s_dec_next.rs2      = o_rs2_addr;
        s_dec_next.use_imm  = s_use_imm;
        s_dec_next.imm      = s_imm;
        s_dec_next.alu_op   = s_alu_op;
        s_dec_next.reg_we   = s_supported && (s_rd != '0);
        s_dec_next.rs1_data = i_rs1_data;
        s_dec_next.rs2_data = i_rs2_data;
    end

    always_ff @(posedge i_clk) begin
        o_dec <= s_dec_next;
        if (!i_rst_n) begin
            o_dec.valid <= 1'b0;
        end
    end

endmodule

//--- logic/execute_stage.sv
// Execute stage with forwarding

`timescale 1ns/100ps

`include "core_defs.svh"

module execute_stage import core_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  dec_pkt_t i_dec,
    input  wb_pkt_t  i_res,
    output wb_pkt_t  o_exe
);

    xlen_t                s_op_a;
    xlen_t                s_rs2_val;
    xlen_t                s_op_b;
    logic [`SHAMT_W-1:0]  s_shamt;
    xlen_t                s_alu_result;

    // Own output is newest and wins over the result stage.
    function automatic xlen_t forward_operand(
        input reg_addr_t addr,
        input xlen_t     reg_data,
        input wb_pkt_t   exe,
        input wb_pkt_t   res
    );
        if (exe.valid && (exe.rd == addr)) begin
            return exe.data;
        end
        if (res.valid && (res.rd == addr)) begin
            return res.data;
        end
        return reg_data;
    endfunction

    // --------------------
    // Operand select.
    // --------------------
    assign s_op_a    = forward_operand(i_dec.rs1, i_dec.rs1_data, o_exe, i_res);
    assign s_rs2_val = forward_operand(i_dec.rs2, i_dec.rs2_data, o_exe, i_res);
    assign s_op_b    = i_dec.use_imm ? i_dec.imm : s_rs2_val;

    // RV64 shifts use the low six bits.
    assign s_shamt = s_op_b[`SHAMT_W-1:0];

    // --------------------
    // ALU.
    // --------------------
    always_comb begin
        case (i_dec.alu_op)
            ALU_ADD:  s_alu_result = s_op_a + s_op_b;
            ALU_SUB:  s_alu_result = s_op_a - s_op_b;
            ALU_AND:  s_alu_result = s_op_a & s_op_b;
            ALU_OR:   s_alu_result = s_op_a | s_op_b;
            ALU_XOR:  s_alu_result = s_op_a ^ s_op_b;
            ALU_SLT: begin
                s_alu_result = {{(`XLEN-1){1'b0}}, $signed(s_op_a) < $signed(s_op_b)};
            end
            ALU_SLTU: begin
                s_alu_result = {{(`XLEN-1){1'b0}}, s_op_a < s_op_b};
            end
            ALU_SLL:  s_alu_result = s_op_a << s_shamt;
            ALU_SRL:  s_alu_result = s_op_a >> s_shamt;
            ALU_SRA:  s_alu_result = xlen_t'($signed(s_op_a) >>> s_shamt);
            default:  s_alu_result = s_op_b;
        endcase
    end

    // Only real register writes leave this stage as valid.
    always_ff @(posedge i_clk) begin
        o_exe.valid <= i_dec.valid && i_dec.reg_we;
        o_exe.rd    <= i_dec.rd;
        o_exe.data  <= s_alu_result;
        if (!i_rst_n) begin
            o_exe.valid <= 1'b0;
        end
    end

endmodule

//--- logic/result_stage.sv
// Result register and register file

`timescale 1ns/100ps

`include "core_defs.svh"

module result_stage import core_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  wb_pkt_t   i_exe,
    input  reg_addr_t i_rs1_addr,
    input  reg_addr_t i_rs2_addr,
    output xlen_t     o_rs1_data,
    output xlen_t     o_rs2_data,
    output wb_pkt_t   o_res
);

    xlen_t s_regs [`NUM_REGS];

    // Reads x0 as zero and bypasses a same-edge write.
    function automatic xlen_t read_port(
        input reg_addr_t addr,
        input wb_pkt_t   wr,
        input xlen_t     stored
    );
        if (addr == '0) begin
            return '0;
        end
        if (wr.valid && (wr.rd == addr)) begin
            return wr.data;
        end
        return stored;
    endfunction

    // --------------------
    // Result register.
    // --------------------
    always_ff @(posedge i_clk) begin
        o_res <= i_exe;
        if (!i_rst_n) begin
            o_res.valid <= 1'b0;
        end
    end

    // --------------------
    // Register file.
    // --------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                s_regs[i] <= '0;
            end
        end else if (o_res.valid) begin
            s_regs[o_res.rd] <= o_res.data;
        end
    end

    // Read ports for decode.
    assign o_rs1_data = read_port(i_rs1_addr, o_res, s_regs[i_rs1_addr]);
    assign o_rs2_data = read_port(i_rs2_addr, o_res, s_regs[i_rs2_addr]);

endmodule

//--- logic/int_pipeline.sv
// Three-stage integer pipeline

`timescale 1ns/100ps

module int_pipeline import core_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_instr_valid,
    input  instr_t    i_instr,
    output logic      o_wb_valid,
    output reg_addr_t o_wb_rd,
    output xlen_t     o_wb_data
);

    reg_addr_t s_rs1_addr;
    reg_addr_t s_rs2_addr;
    xlen_t     s_rs1_data;
    xlen_t     s_rs2_data;
    dec_pkt_t  s_dec;
    wb_pkt_t   s_exe;
    wb_pkt_t   s_res;

    decode_stage u_decode (
        .i_clk         ( i_clk         ),
        .i_rst_n       ( i_rst_n       ),
        .i_instr_valid ( i_instr_valid ),
        .i_instr       ( i_instr       ),
        .i_rs1_data    ( s_rs1_data    ),
        .i_rs2_data    ( s_rs2_data    ),
        .o_rs1_addr    ( s_rs1_addr    ),
        .o_rs2_addr    ( s_rs2_addr    ),
        .o_dec         ( s_dec         )
    );

    execute_stage u_execute (
        .i_clk   ( i_clk   ),
        .i_rst_n ( i_rst_n ),
        .i_dec   ( s_dec   ),
        .i_res   ( s_res   ),
        .o_exe   ( s_exe   )
    );

    result_stage u_result (
        .i_clk      ( i_clk      ),
        .i_rst_n    ( i_rst_n    ),
        .i_exe      ( s_exe      ),
        .i_rs1_addr ( s_rs1_addr ),
        .i_rs2_addr ( s_rs2_addr ),
        .o_rs1_data ( s_rs1_data ),
        .o_rs2_data ( s_rs2_data ),
        .o_res      ( s_res      )
    );

    // Retired write shown one cycle before it lands in the file.
    assign o_wb_valid = s_res.valid;
    assign o_wb_rd    = s_res.rd;
    assign o_wb_data  = s_res.data;

endmodule

//--- verification/int_pipeline_properties.sv
// Pipeline port assertions

`timescale 1ns/100ps

module int_pipeline_properties import core_pkg::*; (
    input logic      i_clk,
    input logic      i_rst_n,
    input logic      i_instr_valid,
    input logic      o_wb_valid,
    input reg_addr_t o_wb_rd
);

    // Fixed latency of three cycles.
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_wb_valid |-> $past(i_instr_valid, 3))
        else $error("write retired without an instruction three cycles earlier");

    // x0 never retires.
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_wb_valid |-> (o_wb_rd != '0))
        else $error("write retired to register x0");

    // Quiet for three cycles once reset is released.
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_wb_valid |-> ($past(i_rst_n, 1) && $past(i_rst_n, 2) && $past(i_rst_n, 3)))
        else $error("write retired too soon after reset");

endmodule

bind int_pipeline int_pipeline_properties u_properties (
    .i_clk         ( i_clk         ),
    .i_rst_n       ( i_rst_n       ),
    .i_instr_valid ( i_instr_valid ),
    .o_wb_valid    ( o_wb_valid    ),
    .o_wb_rd       ( o_wb_rd       )
);

//--- verification/int_pipeline_tb.sv
// Integer pipeline testbench

`timescale 1ns/100ps

`include "core_defs.svh"

module int_pipeline_tb import core_pkg::*; ();

    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam int NUM_RANDOM = 200;
    // About 300 issued instructions plus reset and drain, with margin.
    localparam int TIMEOUT_CYCLES = 5 * (NUM_RANDOM + 100);

    logic      i_clk;
    logic      i_rst_n;
    logic      i_instr_valid;
    instr_t    i_instr;
    logic      o_wb_valid;
    reg_addr_t o_wb_rd;
    xlen_t     o_wb_data;

    xlen_t       model_regs [`NUM_REGS];
    reg_addr_t   exp_rd_q [$];
    xlen_t       exp_data_q [$];
    string       test_name;
    int          checks;
    int          errors;
    int          cycles;
    logic [63:0] rng;
    logic [2:0]  imm_ops [5];

    int_pipeline UUT (
        .i_clk         ( i_clk         ),
        .i_rst_n       ( i_rst_n       ),
        .i_instr_valid ( i_instr_valid ),
        .i_instr       ( i_instr       ),
        .o_wb_valid    ( o_wb_valid    ),
        .o_wb_rd       ( o_wb_rd       ),
        .o_wb_data     ( o_wb_data     )
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic compare(input string what, input xlen_t expected, input xlen_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("error %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    function automatic logic [63:0] xorshift(input logic [63:0] s);
        logic [63:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        return x;
    endfunction

    // --------------------
    // Instruction encoders.
    // --------------------
    function automatic instr_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                     input reg_addr_t rd, input reg_addr_t rs1,
                                     input reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic instr_t enc_i(input logic [2:0] f3, input reg_addr_t rd,
                                     input reg_addr_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, `OPC_OP_IMM};
    endfunction

    function automatic instr_t enc_u(input reg_addr_t rd, input logic [19:0] imm);
        return {imm, rd, `OPC_LUI};
    endfunction

    // Reference ALU from the RV64I definitions.
    function automatic xlen_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input xlen_t a, input xlen_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[5:0];
            3'b010:  return xlen_t'($signed(a) < $signed(b));
            3'b011:  return xlen_t'(a < b);
            3'b100:  return a ^ b;
            3'b101:  return alt ? xlen_t'($signed(a) >>> b[5:0]) : a >> b[5:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // Drive one instruction and update the model.
    task automatic issue(input instr_t ins);
        xlen_t      r;
        logic       ok;
        logic [2:0] f3;
        reg_addr_t  rd;
        @(negedge i_clk);
        i_instr_valid = 1'b1;
        i_instr = ins;
        f3 = ins[14:12];
        rd = ins[11:7];
        r = '0;
        ok = 1'b0;
        case (ins[6:0])
            `OPC_LUI: begin
                ok = 1'b1;
                r = {{32{ins[31]}}, ins[31:12], 12'h000};
            end
            `OPC_OP_IMM: begin
                ok = (f3 != `FUNCT3_SLL) && (f3 != `FUNCT3_SLTU) && (f3 != `FUNCT3_SR);
                r = alu_ref(f3, 1'b0, model_regs[ins[19:15]], {{52{ins[31]}}, ins[31:20]});
            end
            `OPC_OP: begin
                ok = (ins[31:25] == 7'h00) ||
                     ((ins[31:25] == 7'h20) && ((f3 == 3'b000) || (f3 == 3'b101)));
                r = alu_ref(f3, ins[30], model_regs[ins[19:15]], model_regs[ins[24:20]]);
            end
            default: ok = 1'b0;
        endcase
        if (ok && (rd != '0)) begin
            model_regs[rd] = r;
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(r);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge i_clk);
            i_instr_valid = 1'b0;
        end
    endtask

    task automatic end_test();
        idle(4);
        if (exp_rd_q.size() != 0) begin
            errors++;
            $display("%0d expected writes never retired in test %s", exp_rd_q.size(), test_name);
            exp_rd_q.delete();
            exp_data_q.delete();
        end
        $display("test %s finished, %0d errors so far", test_name, errors);
    endtask

    // Retired writes are checked in order.
    always @(negedge i_clk) begin
        if (i_rst_n && o_wb_valid) begin
            if (exp_rd_q.size() == 0) begin
                errors++;
                $display("unexpected write to x%0d in test %s", o_wb_rd, test_name);
            end else begin
                compare("rd", xlen_t'(exp_rd_q.pop_front()), xlen_t'(o_wb_rd));
                compare("data", exp_data_q.pop_front(), o_wb_data);
            end
        end
    end

    // --------------------
    // Directed tests.
    // --------------------
    task automatic test_reset();
        test_name = "reset";
        repeat (3) begin
            @(negedge i_clk);
            compare("valid", '0, xlen_t'(o_wb_valid));
        end
        i_rst_n = 1'b1;
        repeat (4) begin
            @(negedge i_clk);
            compare("valid", '0, xlen_t'(o_wb_valid));
        end
        end_test();
    endtask

    task automatic test_alu();
        test_name = "alu";
        issue(enc_u(5'd1, 20'h80001));
        issue(enc_i(3'b000, 5'd1, 5'd1, 12'hffb));
        issue(enc_i(3'b000, 5'd2, 5'd0, 12'd37));
        issue(enc_i(3'b000, 5'd3, 5'd0, 12'hf85));
        for (int f = 0; f < 8; f++) begin
            issue(enc_r(7'h00, f[2:0], reg_addr_t'(8 + f), 5'd1, 5'd2));
        end
        issue(enc_r(7'h20, 3'b000, 5'd16, 5'd1, 5'd3));
        issue(enc_r(7'h20, 3'b101, 5'd17, 5'd1, 5'd2));
        for (int k = 0; k < 5; k++) begin
            issue(enc_i(imm_ops[k], reg_addr_t'(24 + k), 5'd3, 12'h9a5));
        end
        end_test();
    endtask

    task automatic test_forwarding();
        test_name = "forwarding";
        for (int d = 1; d <= 4; d++) begin
            for (int gap = 0; gap < 2; gap++) begin
                repeat (3) begin
                    issue(enc_i(3'b000, 5'd20, 5'd20, 12'(13 * d + gap)));
                    idle(gap);
                    for (int f = 1; f < d; f++) begin
                        issue(enc_i(3'b100, 5'd21, 5'd21, 12'h055));
                        idle(gap);
                    end
                    issue(enc_r(7'h00, 3'b000, 5'd22, 5'd20, 5'd22));
                end
            end
        end
        end_test();
    endtask

    task automatic test_x0();
        test_name = "x0";
        issue(enc_i(3'b000, 5'd0, 5'd1, 12'd5));
        issue(enc_u(5'd0, 20'h12345));
        issue(enc_r(7'h00, 3'b000, 5'd23, 5'd0, 5'd0));
        issue(enc_r(7'h00, 3'b110, 5'd24, 5'd0, 5'd1));
        end_test();
    endtask

    task automatic test_unsupported();
        test_name = "unsupported";
        // Store whose rd field points at a live register.
        issue({7'h00, 5'd2, 5'd1, 3'b011, 5'd8, OPC_STORE});
        issue(enc_r(7'h00, 3'b000, 5'd26, 5'd8, 5'd0));
        issue(enc_r(7'h00, 3'b000, 5'd27, 5'd16, 5'd17));
        end_test();
    endtask

    task automatic test_random();
        logic [2:0] f3;
        logic [6:0] f7;
        test_name = "random";
        for (int n = 0; n < NUM_RANDOM; n++) begin
            rng = xorshift(rng);
            f3 = rng[2:0];
            f7 = (rng[50] && ((f3 == 3'b000) || (f3 == 3'b101))) ? 7'h20 : 7'h00;
            case (rng[19:18])
                2'd0:    issue(enc_u(rng[7:3], rng[39:20]));
                2'd1:    issue(enc_i(imm_ops[int'(rng[42:40]) % 5], rng[7:3], rng[12:8],
                                     rng[63:52]));
                default: issue(enc_r(f7, f3, rng[7:3], rng[12:8], rng[17:13]));
            endcase
        end
        end_test();
    endtask

    initial begin
        i_rst_n = 1'b0;
        i_instr_valid = 1'b0;
        i_instr = '0;
        checks = 0;
        errors = 0;
        cycles = 0;
        rng = 64'd79;
        imm_ops = '{3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
        test_reset();
        test_alu();
        test_forwarding();
        test_x0();
        test_unsupported();
        test_random();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+logic
logic/core_pkg.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/int_pipeline.sv
verification/int_pipeline_properties.sv
verification/int_pipeline_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module int_pipeline_tb -o int_pipeline_sim
./obj_dir/int_pipeline_sim | tee sim.log

if grep -q "Test failures found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation PASSED"
